// File: include/clockSynthDefs.svh
// Clock synthesizer shared field widths for configuration and status
`ifndef CLOCK_SYNTH_DEFS_SVH
`define CLOCK_SYNTH_DEFS_SVH

`define PRESCALE_W 4   // Reference prescaler ratio field
`define MUL_INT_W  11  // Multiplier integer part
`define MUL_FRAC_W 12  // Multiplier fractional part
`define LDET_W     9   // Lock detector config, MSB is force lock
`define L2_W       8   // Output L2 divide ratio

`endif

// File: hdl/pllCfgPkg.sv
// Clock synthesizer configuration package, field widths and divider codes
package pllCfgPkg;

  `include "clockSynthDefs.svh"

  // --------------------------------------------------------------------------
  // Configuration field widths
  // --------------------------------------------------------------------------
  localparam int PRESCALE_W = `PRESCALE_W;  // CK_XTAL_IN prescale ratio
  localparam int MUL_INT_W  = `MUL_INT_W;   // Integer multiplier
  localparam int MUL_FRAC_W = `MUL_FRAC_W;  // Fractional multiplier
  localparam int LDET_W     = `LDET_W;      // Lock detector settings
  localparam int L2_W       = `L2_W;        // Default L2 divider width

  localparam int LDET_FORCE_BIT = LDET_W - 1;  // Forces LOCKED high when set

  // Widest L1 predivide is 8, so a 3 bit counter covers every code
  localparam int L1_CNT_W = 3;

  // L1 predivide code, ratio is 2 to the power of the code
  typedef enum logic [1:0] {
    L1_DIV1 = 2'd0,  // Divide by 1
    L1_DIV2 = 2'd1,  // Divide by 2
    L1_DIV4 = 2'd2,  // Divide by 4
    L1_DIV8 = 2'd3   // Divide by 8
  } l1Code_t;

endpackage

// File: hdl/pllStatusPkg.sv
// Clock synthesizer lock status package, detector states and counter width
package pllStatusPkg;

  `include "clockSynthDefs.svh"

  // --------------------------------------------------------------------------
  // Lock detector
  // --------------------------------------------------------------------------

  // Settle count field is the lock detector config minus its force bit
  localparam int SETTLE_W = `LDET_W - 1;

  typedef enum logic [1:0] {
    LK_RESET  = 2'd0,  // Just out of reset, capture config
    LK_SETTLE = 2'd1,  // Counting reference ticks
    LK_LOCKED = 2'd2   // Settled with no config change
  } lockState_t;

endpackage

// File: hdl/refPrescaler.sv
// Reference prescaler, one cycle tick every PRESCALE+1 crystal clocks
`timescale 1ns/1ps

module refPrescaler
  import pllCfgPkg::*;
(
  input  logic                  CK_XTAL_IN,  // Crystal reference clock
  input  logic                  RST_N,       // Async reset, active low
  input  logic [PRESCALE_W-1:0] PRESCALE,    // Divide ratio minus one
  output logic                  refTick      // One cycle pulse
);

  logic [PRESCALE_W-1:0] preCnt;   // Down counter
  logic                  cntZero;  // Counter at terminal value

  assign cntZero = (preCnt == '0);

  // --------------------------------------------------------------------------
  // Down counter with reload
  // --------------------------------------------------------------------------
  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      preCnt <= '0;
    end else if (cntZero) begin
      preCnt <= PRESCALE;                 // Reload for next period
    end else begin
      preCnt <= preCnt - 1'b1;
    end
  end

  // Tick registered so it is clean and low out of reset
  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      refTick <= 1'b0;
    end else begin
      refTick <= cntZero;                 // High every cycle when PRESCALE is 0
    end
  end

endmodule

// File: hdl/lockDetector.sv
// Lock detector, drops LOCKED on multiplier config change and times relock
`timescale 1ns/1ps

module lockDetector
  import pllCfgPkg::*;
  import pllStatusPkg::*;
#(
  parameter int SettleWidth = SETTLE_W  // Settle counter width
) (
  input  logic                  CK_XTAL_IN,    // Crystal reference clock
  input  logic                  RST_N,         // Async reset, active low
  input  logic                  refTick,       // Prescaled reference tick
  input  logic [PRESCALE_W-1:0] PRESCALE,      // Prescaler ratio
  input  logic [MUL_INT_W-1:0]  MUL_INT,       // Integer multiplier
  input  logic [MUL_FRAC_W-1:0] MUL_FRAC,      // Fractional multiplier
  input  logic                  INTEGER_MODE,  // Integer mode select
  input  logic [LDET_W-1:0]     LDET_CONFIG,   // Force bit and settle count
  output logic                  LOCKED         // Lock indication
);

  // Every field whose change forces a relock
  localparam int CFG_W = PRESCALE_W + MUL_INT_W + MUL_FRAC_W + 1;

  logic [CFG_W-1:0]       cfgNow;        // Current configuration
  logic [CFG_W-1:0]       cfgReg;        // Configuration seen last clock
  logic                   cfgChange;     // Any field differs
  logic                   forceLock;     // LDET_CONFIG MSB
  logic [SettleWidth-1:0] settleTarget;  // Ticks to wait, minus one
  logic [SettleWidth-1:0] settleCnt;     // Ticks counted so far
  logic                   settleDone;    // Last tick of settling
  lockState_t             state;         // Detector FSM

  assign cfgNow       = {PRESCALE, MUL_INT, MUL_FRAC, INTEGER_MODE};
  assign cfgChange    = (cfgNow != cfgReg);
  assign forceLock    = LDET_CONFIG[LDET_FORCE_BIT];
  assign settleTarget = SettleWidth'(LDET_CONFIG[LDET_FORCE_BIT-1:0]);
  assign settleDone   = refTick && (settleCnt == settleTarget);

  // --------------------------------------------------------------------------
  // Configuration snapshot
  // --------------------------------------------------------------------------
  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      cfgReg <= '0;
    end else begin
      cfgReg <= cfgNow;                   // Follow config every clock
    end
  end

  // --------------------------------------------------------------------------
  // Lock FSM and settle counter
  // --------------------------------------------------------------------------
  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      state     <= LK_RESET;
      settleCnt <= '0;
    end else begin
      case (state)
        LK_RESET: begin
          state     <= LK_SETTLE;         // Snapshot taken this clock
          settleCnt <= '0;
        end
        LK_SETTLE: begin
          if (cfgChange) begin
            settleCnt <= '0;              // Restart settling
          end else if (settleDone) begin
            state     <= LK_LOCKED;
            settleCnt <= '0;
          end else if (refTick) begin
            settleCnt <= settleCnt + 1'b1;
          end
        end
        LK_LOCKED: begin
          if (cfgChange) begin
            state     <= LK_SETTLE;       // Drop lock next clock
            settleCnt <= '0;
          end
        end
        default: begin
          state     <= LK_RESET;
          settleCnt <= '0;
        end
      endcase
    end
  end

  // Force bit overrides the FSM and ignores config changes
  assign LOCKED = forceLock || (state == LK_LOCKED);

endmodule

// File: hdl/outputDivider.sv
// Output clock channel, L1 power of two and L2 division with enable and bypass
`timescale 1ns/1ps

module outputDivider
  import pllCfgPkg::*;
#(
  parameter int L2Width = L2_W  // L2 divide field width
) (
  input  logic               CK_XTAL_IN,  // Crystal reference clock
  input  logic               RST_N,       // Async reset, active low
  input  logic               CK_AUX_IN,   // Bypass clock
  input  logic               locked,      // Lock from detector
  input  logic               EN,          // Channel enable
  input  logic               BYPASS,      // Select CK_AUX_IN
  input  l1Code_t            L1,          // L1 predivide code
  input  logic [L2Width-1:0] L2,          // L2 ratio minus one
  output logic               ckOut        // Channel clock output
);

  logic                run;    // Divider active
  logic [L1_CNT_W-1:0] l1Max;  // Terminal count of L1 stage
  logic [L1_CNT_W-1:0] l1Cnt;  // L1 counter
  logic                l1Tick; // One clock per L1 period
  logic [L2Width-1:0]  l2Cnt;  // L2 counter of L1 ticks
  logic                l2Hit;  // L2 reached its ratio
  logic                divClk; // Registered divided clock

  assign run = EN && locked;

  // L1 terminal count from the code
  always_comb begin
    case (L1)
      L1_DIV1: l1Max = L1_CNT_W'(0);
      L1_DIV2: l1Max = L1_CNT_W'(1);
      L1_DIV4: l1Max = L1_CNT_W'(3);
      L1_DIV8: l1Max = L1_CNT_W'(7);
      default: l1Max = L1_CNT_W'(0);
    endcase
  end

  assign l1Tick = (l1Cnt == l1Max);
  assign l2Hit  = (l2Cnt == L2);

  // --------------------------------------------------------------------------
  // L1 predivider
  // --------------------------------------------------------------------------
  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      l1Cnt <= '0;
    end else if (!run || l1Tick) begin
      l1Cnt <= '0;                        // Restart on stop or wrap
    end else begin
      l1Cnt <= l1Cnt + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // L2 divider and output toggle
  // --------------------------------------------------------------------------
  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      l2Cnt  <= '0;
      divClk <= 1'b0;
    end else if (!run) begin
      l2Cnt  <= '0;                       // Restart from a low phase
      divClk <= 1'b0;
    end else if (l1Tick) begin
      if (l2Hit) begin
        l2Cnt  <= '0;
        divClk <= ~divClk;                // Half period of 2^L1*(L2+1)
      end else begin
        l2Cnt <= l2Cnt + 1'b1;
      end
    end
  end

  // Gate holds the output low the same clock EN or lock falls,
  // bypass wins regardless of lock and enable
  assign ckOut = BYPASS ? CK_AUX_IN : (divClk && run);

endmodule

// File: hdl/clockSynth.sv
// Clock synthesizer top, prescaler, lock detector and two output channels
`timescale 1ns/1ps

module clockSynth
  import pllCfgPkg::*;
  import pllStatusPkg::*;
#(
  parameter int L2Width     = L2_W,     // Output L2 field width
  parameter int SettleWidth = SETTLE_W  // Lock settle counter width
) (
  input  logic                        CK_XTAL_IN,    // Crystal reference clock
  input  logic                        RST_N,         // Async reset, active low
  input  logic                        CK_AUX_IN,     // Bypass clock
  input  logic [PRESCALE_W-1:0]       PRESCALE,      // Reference prescale ratio
  input  logic                        INTEGER_MODE,  // Integer mode select
  input  logic [MUL_INT_W-1:0]        MUL_INT,       // Integer multiplier
  input  logic [MUL_FRAC_W-1:0]       MUL_FRAC,      // Fractional multiplier
  input  logic [LDET_W-1:0]           LDET_CONFIG,   // Lock detector settings
  input  logic                        PS0_EN,        // Channel 0 enable
  input  logic                        PS0_BYPASS,    // Channel 0 bypass
  input  logic [$bits(l1Code_t)-1:0]  PS0_L1,        // Channel 0 L1 code
  input  logic [L2Width-1:0]          PS0_L2,        // Channel 0 L2 ratio
  input  logic                        PS1_EN,        // Channel 1 enable
  input  logic                        PS1_BYPASS,    // Channel 1 bypass
  input  logic [$bits(l1Code_t)-1:0]  PS1_L1,        // Channel 1 L1 code
  input  logic [L2Width-1:0]          PS1_L2,        // Channel 1 L2 ratio
  output logic                        LOCKED,        // Lock indication
  output logic                        CK_PLL_OUT0,   // Channel 0 clock
  output logic                        CK_PLL_OUT1    // Channel 1 clock
);

  logic refTick;  // Prescaled reference tick

  // --------------------------------------------------------------------------
  // Reference and lock
  // --------------------------------------------------------------------------
  refPrescaler uPrescaler (
    .CK_XTAL_IN (CK_XTAL_IN),
    .RST_N      (RST_N),
    .PRESCALE   (PRESCALE),
    .refTick    (refTick)
  );

  lockDetector #(
    .SettleWidth (SettleWidth)
  ) uLockDet (
    .CK_XTAL_IN   (CK_XTAL_IN),
    .RST_N        (RST_N),
    .refTick      (refTick),
    .PRESCALE     (PRESCALE),
    .MUL_INT      (MUL_INT),
    .MUL_FRAC     (MUL_FRAC),
    .INTEGER_MODE (INTEGER_MODE),
    .LDET_CONFIG  (LDET_CONFIG),
    .LOCKED       (LOCKED)
  );

  // --------------------------------------------------------------------------
  // Output channels
  // --------------------------------------------------------------------------
  outputDivider #(
    .L2Width (L2Width)
  ) ps0 (
    .CK_XTAL_IN (CK_XTAL_IN),
    .RST_N      (RST_N),
    .CK_AUX_IN  (CK_AUX_IN),
    .locked     (LOCKED),
    .EN         (PS0_EN),
    .BYPASS     (PS0_BYPASS),
    .L1         (l1Code_t'(PS0_L1)),   // Raw code to enum
    .L2         (PS0_L2),
    .ckOut      (CK_PLL_OUT0)
  );

  outputDivider #(
    .L2Width (L2Width)
  ) ps1 (
    .CK_XTAL_IN (CK_XTAL_IN),
    .RST_N      (RST_N),
    .CK_AUX_IN  (CK_AUX_IN),
    .locked     (LOCKED),
    .EN         (PS1_EN),
    .BYPASS     (PS1_BYPASS),
    .L1         (l1Code_t'(PS1_L1)),
    .L2         (PS1_L2),
    .ckOut      (CK_PLL_OUT1)
  );

endmodule

// File: testbench/clockSynth_assert.sv
// Concurrent assertion checker for clockSynth lock timing, output period, gating and bypass
`timescale 1ns/1ps

module clockSynthChecks
  import pllCfgPkg::*;
(
  input logic                  CK_XTAL_IN,
  input logic                  RST_N,
  input logic                  CK_AUX_IN,
  input logic [PRESCALE_W-1:0] PRESCALE,
  input logic                  INTEGER_MODE,
  input logic [MUL_INT_W-1:0]  MUL_INT,
  input logic [MUL_FRAC_W-1:0] MUL_FRAC,
  input logic [LDET_W-1:0]     LDET_CONFIG,
  input logic                  PS0_EN,
  input logic                  PS0_BYPASS,
  input logic [1:0]            PS0_L1,
  input logic [L2_W-1:0]       PS0_L2,
  input logic                  PS1_EN,
  input logic                  PS1_BYPASS,
  input logic [1:0]            PS1_L1,
  input logic [L2_W-1:0]       PS1_L2,
  input logic                  LOCKED,
  input logic                  CK_PLL_OUT0,
  input logic                  CK_PLL_OUT1
);

  localparam int CFG_W = PRESCALE_W + MUL_INT_W + MUL_FRAC_W + 1;

  int               errCount = 0;  // Failed assertions so far
  logic [CFG_W-1:0] cfgNow;        // Fields that force relock
  logic [CFG_W-1:0] cfgPrev;       // Same fields one clock back
  logic             cfgDiff;       // Config moved this clock
  logic             forceBit;      // LDET_CONFIG MSB
  int               stableCnt;     // Clocks since last config change
  int               settleN;       // Settle ticks
  int               preN;          // Clocks per reference tick
  logic             run0, run1;    // Channel dividing
  logic             out0Q, out1Q;  // Output one clock back
  logic             byp0Q, byp1Q;  // Bypass one clock back
  logic             tog0, tog1;    // Divided output toggled
  int               half0, half1;  // Clocks since last toggle or -1 when unknown
  int               exp0, exp1;    // Expected half periods

  assign cfgNow   = {PRESCALE, MUL_INT, MUL_FRAC, INTEGER_MODE};
  assign cfgDiff  = (cfgNow != cfgPrev);
  assign forceBit = LDET_CONFIG[LDET_W-1];
  assign settleN  = int'(LDET_CONFIG[LDET_W-2:0]) + 1;
  assign preN     = int'(PRESCALE) + 1;
  assign run0     = PS0_EN && LOCKED;
  assign run1     = PS1_EN && LOCKED;
  assign tog0     = (CK_PLL_OUT0 != out0Q) && !PS0_BYPASS && !byp0Q;
  assign tog1     = (CK_PLL_OUT1 != out1Q) && !PS1_BYPASS && !byp1Q;
  assign exp0     = (1 << PS0_L1) * (int'(PS0_L2) + 1);  // 2^L1 * (L2+1)
  assign exp1     = (1 << PS1_L1) * (int'(PS1_L2) + 1);

  // ------------------------------------------------------------------------
  // Reference models of config history and divider phase
  // ------------------------------------------------------------------------
  always_ff @(posedge CK_XTAL_IN or negedge RST_N) begin
    if (!RST_N) begin
      cfgPrev   <= '0;                   // Mirrors the detector snapshot
      stableCnt <= 0;
      out0Q     <= 1'b0;
      out1Q     <= 1'b0;
      byp0Q     <= 1'b0;
      byp1Q     <= 1'b0;
      half0     <= 0;
      half1     <= 0;
    end else begin
      cfgPrev   <= cfgNow;
      stableCnt <= cfgDiff ? 0 : stableCnt + 1;
      out0Q     <= CK_PLL_OUT0;
      out1Q     <= CK_PLL_OUT1;
      byp0Q     <= PS0_BYPASS;
      byp1Q     <= PS1_BYPASS;
      // Divider keeps running behind bypass so its phase is unknown there
      half0     <= !run0 ? 0 : (PS0_BYPASS || byp0Q) ? -1 :
                   tog0 ? 1 : (half0 < 0 ? -1 : half0 + 1);
      half1     <= !run1 ? 0 : (PS1_BYPASS || byp1Q) ? -1 :
                   tog1 ? 1 : (half1 < 0 ? -1 : half1 + 1);
    end
  end

  // ------------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------------
  lockDrop: assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    cfgDiff && !forceBit |=> !LOCKED)
    else begin
      errCount++;
      $error("LOCKED still high after config change");
    end

  // Window width is the prescaler phase at the change
  lockRise: assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    $rose(LOCKED) && !forceBit |->
      stableCnt >= (settleN - 1) * preN + 1 && stableCnt <= settleN * preN)
    else begin
      errCount++;
      $error("LOCKED rose after %0d clocks", stableCnt);
    end

  halfPeriod0: assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    run0 && tog0 && half0 >= 0 |-> half0 == exp0)
    else begin
      errCount++;
      $error("Channel 0 half period %0d, want %0d", half0, exp0);
    end

  halfPeriod1: assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    run1 && tog1 && half1 >= 0 |-> half1 == exp1)
    else begin
      errCount++;
      $error("Channel 1 half period %0d, want %0d", half1, exp1);
    end

  gate0: assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    !PS0_BYPASS && !run0 |-> !CK_PLL_OUT0)
    else begin
      errCount++;
      $error("Channel 0 not held low");
    end

  gate1: assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    !PS1_BYPASS && !run1 |-> !CK_PLL_OUT1)
    else begin
      errCount++;
      $error("Channel 1 not held low");
    end

  bypass0: assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    PS0_BYPASS |-> CK_PLL_OUT0 == CK_AUX_IN)
    else begin
      errCount++;
      $error("Channel 0 bypass mismatch");
    end

  bypass1: assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    PS1_BYPASS |-> CK_PLL_OUT1 == CK_AUX_IN)
    else begin
      errCount++;
      $error("Channel 1 bypass mismatch");
    end

  forcedLock: assert property (@(posedge CK_XTAL_IN) disable iff (!RST_N)
    forceBit |-> LOCKED)
    else begin
      errCount++;
      $error("LOCKED low with force bit set");
    end

endmodule

bind clockSynth clockSynthChecks checks (
  .CK_XTAL_IN   (CK_XTAL_IN),
  .RST_N        (RST_N),
  .CK_AUX_IN    (CK_AUX_IN),
  .PRESCALE     (PRESCALE),
  .INTEGER_MODE (INTEGER_MODE),
  .MUL_INT      (MUL_INT),
  .MUL_FRAC     (MUL_FRAC),
  .LDET_CONFIG  (LDET_CONFIG),
  .PS0_EN       (PS0_EN),
  .PS0_BYPASS   (PS0_BYPASS),
  .PS0_L1       (PS0_L1),
  .PS0_L2       (PS0_L2),
  .PS1_EN       (PS1_EN),
  .PS1_BYPASS   (PS1_BYPASS),
  .PS1_L1       (PS1_L1),
  .PS1_L2       (PS1_L2),
  .LOCKED       (LOCKED),
  .CK_PLL_OUT0  (CK_PLL_OUT0),
  .CK_PLL_OUT1  (CK_PLL_OUT1)
);

// File: testbench/clockSynthTb.sv
// Testbench for clockSynth covering lock, divider, gating, bypass and forced lock phases
`timescale 1ns/1ps

module clockSynthTb
  import pllCfgPkg::*;
;

  logic                  CK_XTAL_IN;
  logic                  RST_N;
  logic                  CK_AUX_IN;
  logic [PRESCALE_W-1:0] PRESCALE;
  logic                  INTEGER_MODE;
  logic [MUL_INT_W-1:0]  MUL_INT;
  logic [MUL_FRAC_W-1:0] MUL_FRAC;
  logic [LDET_W-1:0]     LDET_CONFIG;
  logic                  PS0_EN, PS0_BYPASS, PS1_EN, PS1_BYPASS;
  logic [1:0]            PS0_L1, PS1_L1;
  logic [L2_W-1:0]       PS0_L2, PS1_L2;
  logic                  LOCKED, CK_PLL_OUT0, CK_PLL_OUT1;

  int lockMax;        // Clocks allowed for one relock
  int wdCycles;       // Watchdog budget
  bit wdArmed = 0;

  clockSynth dut (.*);

  initial begin
    CK_XTAL_IN = 1'b0;
    forever #4 CK_XTAL_IN = ~CK_XTAL_IN;  // 8 ns period
  end

  // Aux clock changes on falling edges only
  initial begin
    CK_AUX_IN = 1'b0;
    forever begin
      @(negedge CK_XTAL_IN);
      CK_AUX_IN <= 1'($urandom_range(0, 1));
    end
  end

  // ------------------------------------------------------------------------
  // Failure report one clock phase after the assertions sample
  // ------------------------------------------------------------------------
  always @(negedge CK_XTAL_IN) begin
    if (dut.checks.errCount != 0) begin
      $display("[FAIL] %0t ns assertion failure in DUT checker", $time);
      $display("Test failures found");
      $fatal(1, "Stopping on first error");
    end
  end

  initial begin
    wait (wdArmed);
    repeat (wdCycles) @(posedge CK_XTAL_IN);
    $display("Watchdog expired before the tests finished");
    $display("Test failures found");
    $fatal(1, "Watchdog timeout");
  end

  // Wait for LOCKED with a limit
  task automatic waitLocked();
    int n;
    n = 0;
    @(negedge CK_XTAL_IN);                 // A change driven now drops LOCKED first
    while (!LOCKED && n <= lockMax) begin
      @(negedge CK_XTAL_IN);
      n++;
    end
    if (!LOCKED) begin
      $display("LOCKED never rose within %0d clocks", lockMax);
      $display("Test failures found");
      $fatal(1, "Lock timeout");
    end
  endtask

  // Change a multiplier field on the falling edge
  task automatic bumpConfig();
    @(negedge CK_XTAL_IN);
    MUL_FRAC = MUL_FRAC + 12'd1;
  endtask

  // Random L1 and L2 on both channels then several half periods
  task automatic runDividers();
    int h;
    @(negedge CK_XTAL_IN);
    PS0_EN = 1'b0;
    PS1_EN = 1'b0;
    @(negedge CK_XTAL_IN);
    PS0_L1 = 2'($urandom_range(0, 3));
    PS1_L1 = 2'($urandom_range(0, 3));
    PS0_L2 = L2_W'($urandom_range(0, 7));
    PS1_L2 = L2_W'($urandom_range(0, 7));
    PS0_EN = 1'b1;
    PS1_EN = 1'b1;
    h = 64;                                // Largest half period
    repeat (6 * h + 4) @(negedge CK_XTAL_IN);
  endtask

  initial begin
    void'($urandom(32'hfd859363));
    RST_N        = 1'b0;
    PRESCALE     = PRESCALE_W'($urandom_range(0, 3));   // Held for the whole run
    INTEGER_MODE = 1'b1;
    MUL_INT      = 11'd40;
    MUL_FRAC     = 12'h100;
    LDET_CONFIG  = 9'($urandom_range(3, 12));
    PS0_EN       = 1'b0;
    PS1_EN       = 1'b0;
    PS0_BYPASS   = 1'b0;
    PS1_BYPASS   = 1'b0;
    PS0_L1       = 2'd0;
    PS1_L1       = 2'd0;
    PS0_L2       = '0;
    PS1_L2       = '0;
    lockMax  = (int'(LDET_CONFIG) + 2) * (int'(PRESCALE) + 1) + 8;
    wdCycles = 20 + 10 * lockMax + 5 * (6 * 64 + 10) + 300;
    wdArmed  = 1;
    repeat (10) @(posedge CK_XTAL_IN);
    @(negedge CK_XTAL_IN);
    RST_N = 1'b1;

    // ----------------------------------------------------------------------
    // Lock timing for a plain change and a change during settling
    // ----------------------------------------------------------------------
    waitLocked();
    bumpConfig();
    waitLocked();
    bumpConfig();
    repeat (3) @(negedge CK_XTAL_IN);
    INTEGER_MODE = 1'b0;
    waitLocked();

    // Output period with random codes
    repeat (4) runDividers();

    // Gating by enable and by loss of lock
    PS0_EN = 1'b0;
    repeat (20) @(negedge CK_XTAL_IN);
    bumpConfig();
    repeat (4) @(negedge CK_XTAL_IN);
    waitLocked();

    // Bypass while unlocked and disabled
    PS0_BYPASS = 1'b1;
    PS1_BYPASS = 1'b1;
    MUL_INT    = MUL_INT + 11'd3;
    repeat (30) @(negedge CK_XTAL_IN);
    waitLocked();
    PS0_BYPASS = 1'b0;
    PS1_BYPASS = 1'b0;
    PS0_EN     = 1'b1;
    repeat (40) @(negedge CK_XTAL_IN);

    // Forced lock through config changes
    LDET_CONFIG[LDET_W-1] = 1'b1;
    repeat (3) begin
      bumpConfig();
      repeat (5) @(negedge CK_XTAL_IN);
    end
    repeat (4) @(negedge CK_XTAL_IN);

    if (dut.checks.errCount == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "Checker reported errors");
    end
  end

endmodule

// File: src.f
+incdir+include
hdl/pllCfgPkg.sv
hdl/pllStatusPkg.sv
hdl/refPrescaler.sv
hdl/lockDetector.sv
hdl/outputDivider.sv
hdl/clockSynth.sv
testbench/clockSynth_assert.sv
testbench/clockSynthTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= clockSynthTb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
RUNARGS   ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BINARY  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) $(RUNARGS)

clean:
	rm -rf $(OBJDIR)
